// File: sources.f
lpif_flit_pkg.sv
aib_phy_pkg.sv
lpif_auto_sync.sv
lpif_flit_pack.sv
lpif_rx_align_fifo.sv
lpif_flit_unpack.sv
lpif_link_top.sv
tb_lpif_link.sv

// File: Makefile
# Verilator build and run of the link testbench

TOP := tb_lpif_link

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_lpif_link.sv
// Self-checking testbench for the link top, run with a three-stage PHY loopback from tx to rx
`timescale 1ns/1ps

module tb_lpif_link;

  localparam int DELAY_X        = 20;
  localparam int DELAY_Y        = 10;
  localparam int DELAY_Z        = 16;
  localparam int NUM_FLITS      = 300;
  localparam int TIMEOUT_CYCLES = 1000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  logic [79:0] tx_phy0;
  logic [79:0] rx_phy0 = '0;
  logic [79:0] phy_d1  = '0;
  logic [79:0] phy_d2  = '0;
  logic [3:0]  dstrm_state;
  logic [1:0]  dstrm_protid;
  logic [63:0] dstrm_data;
  logic [0:0]  dstrm_dvalid;
  logic [3:0]  dstrm_crc;
  logic [0:0]  dstrm_crc_valid;
  logic [0:0]  dstrm_valid;
  logic [3:0]  ustrm_state;
  logic [1:0]  ustrm_protid;
  logic [63:0] ustrm_data;
  logic [0:0]  ustrm_dvalid;
  logic [3:0]  ustrm_crc;
  logic [0:0]  ustrm_crc_valid;
  logic [0:0]  ustrm_valid;
  logic [31:0] tx_downstream_debug_status;
  logic [31:0] rx_upstream_debug_status;
  logic [0:0]  tx_mrk_userbit;
  logic [15:0] delay_x_value;
  logic [15:0] delay_y_value;
  logic [15:0] delay_z_value;

  // Model state
  logic [31:0] lcg_state;
  logic [76:0] exp_q [$];
  // Last four driven flits, index 0 newest
  logic [76:0] hist_word   [4];
  logic        hist_online [4];
  logic        hist_mrk    [4];
  logic        aligned_model;
  // Expected delayed online levels
  logic        exp_tx_lvl;
  logic        exp_rx_lvl;
  int          tick;
  int          last_stb;
  int          stb_count;
  int          rx_count;
  int          cycle_count = 0;

  always #10 clk = ~clk;

  lpif_link_top #(
    .FIFO_DEPTH (8),
    .FIFO_START (2)
  ) lpif_link_top_inst (
    .clk_wr                     (clk),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy0),
    .rx_phy0                    (rx_phy0),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value)
  );

  // PHY channel loopback, three register stages
  always @(posedge clk) begin
    phy_d1  <= tx_phy0;
    phy_d2  <= phy_d1;
    rx_phy0 <= phy_d2;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected link word, state field on top and flit valid at bit 0
  function automatic logic [76:0] pack_flit(input logic [3:0] st, input logic [1:0] pid,
                                            input logic [63:0] dat, input logic dv,
                                            input logic [3:0] crc, input logic cv,
                                            input logic v);
    return {st, pid, dat, dv, crc, cv, v};
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_with(input string msg);
    $display("Error: %s", msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One cycle of stimulus with transmit side checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic step(input bit quiet);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [78:0] exp_low;
    logic [31:0] exp_dbg;
    @(negedge clk);
    tick++;
    // Both debug words carry the two levels, overflow stays clear
    exp_dbg     = '0;
    exp_dbg[19] = exp_tx_lvl;
    exp_dbg[18] = exp_rx_lvl;
    check_value("tx_downstream_debug_status", 80'(tx_downstream_debug_status),
                80'(exp_dbg));
    check_value("rx_upstream_debug_status", 80'(rx_upstream_debug_status), 80'(exp_dbg));
    // tx_phy0 holds the flit driven one negedge ago
    exp_low = {hist_online[0] & hist_mrk[0], hist_online[0],
               hist_online[0] ? hist_word[0] : 77'd0};
    check_value("tx_phy0[78:0]", 80'(tx_phy0[78:0]), 80'(exp_low));
    // Strobe period
    if (tx_phy0[79]) begin
      if (last_stb >= 0) begin
        check_value("tx_phy0 strobe gap", 80'(tick - last_stb), 80'(DELAY_Z));
      end
      last_stb = tick;
      stb_count++;
    end else if (last_stb >= 0 && tick - last_stb > DELAY_Z) begin
      fail_with("strobe on tx_phy0 did not come back within its period");
    end
    // Word now on rx_phy0 was driven four negedges ago
    if (aligned_model && hist_online[3] && hist_word[3][0]) begin
      exp_q.push_back(hist_word[3]);
    end
    if (!exp_rx_lvl) begin
      aligned_model = 1'b0;
    end else if (rx_phy0[79]) begin
      aligned_model = 1'b1;
    end
    // Next random flit, valid low about one time in four
    lcg_state = lcg_step(lcg_state);
    r1 = lcg_state;
    lcg_state = lcg_step(lcg_state);
    r2 = lcg_state;
    lcg_state = lcg_step(lcg_state);
    r3 = lcg_state;
    dstrm_data      = {r1, r2};
    dstrm_state     = r3[31:28];
    dstrm_protid    = r3[27:26];
    dstrm_dvalid    = r3[25];
    dstrm_crc       = r3[24:21];
    dstrm_crc_valid = r3[20];
    tx_mrk_userbit  = r3[19];
    dstrm_valid     = quiet ? 1'b0 : (r3[17:16] != 2'b00);
    for (int i = 3; i > 0; i--) begin
      hist_word[i]   = hist_word[i-1];
      hist_online[i] = hist_online[i-1];
      hist_mrk[i]    = hist_mrk[i-1];
    end
    hist_word[0]   = pack_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid[0],
                               dstrm_crc, dstrm_crc_valid[0], dstrm_valid[0]);
    hist_online[0] = exp_tx_lvl;
    hist_mrk[0]    = tx_mrk_userbit[0];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Upstream compare and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_flits
    logic [76:0] exp_word;
    logic [3:0]  e_state;
    logic [1:0]  e_protid;
    logic [63:0] e_data;
    logic        e_dvalid;
    logic [3:0]  e_crc;
    logic        e_crc_valid;
    if (rst_n && ustrm_valid[0]) begin
      if (exp_q.size() == 0) begin
        fail_with("a flit came out on ustrm while none was expected");
      end else begin
        exp_word = exp_q.pop_front();
        {e_state, e_protid, e_data, e_dvalid, e_crc, e_crc_valid} = exp_word[76:1];
        check_value("ustrm_state", 80'(ustrm_state), 80'(e_state));
        check_value("ustrm_protid", 80'(ustrm_protid), 80'(e_protid));
        check_value("ustrm_data", 80'(ustrm_data), 80'(e_data));
        check_value("ustrm_dvalid", 80'(ustrm_dvalid), 80'(e_dvalid));
        check_value("ustrm_crc", 80'(ustrm_crc), 80'(e_crc));
        check_value("ustrm_crc_valid", 80'(ustrm_crc_valid), 80'(e_crc_valid));
        rx_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_with("run did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = '0;
    dstrm_crc       = '0;
    dstrm_crc_valid = '0;
    dstrm_valid     = '0;
    tx_mrk_userbit  = '0;
    delay_x_value   = 16'(DELAY_X);
    delay_y_value   = 16'(DELAY_Y);
    delay_z_value   = 16'(DELAY_Z);
    lcg_state       = 32'h51e4_960b;
    aligned_model   = 1'b0;
    exp_tx_lvl      = 1'b0;
    exp_rx_lvl      = 1'b0;
    tick            = 0;
    last_stb        = -1;
    stb_count       = 0;
    rx_count        = 0;
    for (int i = 0; i < 4; i++) begin
      hist_word[i]   = '0;
      hist_online[i] = 1'b0;
      hist_mrk[i]    = 1'b0;
    end
    repeat (5) @(negedge clk);
    // Everything quiet in reset
    check_value("tx_phy0", tx_phy0, 80'd0);
    check_value("ustrm_data", 80'(ustrm_data), 80'd0);
    check_value("ustrm_state", 80'({ustrm_state, ustrm_protid, ustrm_dvalid}), 80'd0);
    check_value("ustrm_crc", 80'({ustrm_crc, ustrm_crc_valid, ustrm_valid}), 80'd0);
    check_value("tx_downstream_debug_status", 80'(tx_downstream_debug_status), 80'd0);
    check_value("rx_upstream_debug_status", 80'(rx_upstream_debug_status), 80'd0);
    rst_n = 1'b1;
    // Offline, strobes only
    repeat (40) step(1'b0);
    if (stb_count < 2) begin
      fail_with("fewer than two strobes seen on tx_phy0 before online");
    end
    // Transmit online after X + 1 edges
    tx_online = 1'b1;
    repeat (DELAY_X + 1) step(1'b0);
    exp_tx_lvl = 1'b1;
    step(1'b0);
    // Receive online after Y + 1 edges
    rx_online = 1'b1;
    repeat (DELAY_Y + 1) step(1'b0);
    exp_rx_lvl = 1'b1;
    step(1'b0);
    // Round trip
    repeat (NUM_FLITS) step(1'b0);
    // Flush the loopback, then drain the buffer
    repeat (6) step(1'b1);
    while (exp_q.size() != 0) begin
      step(1'b1);
    end
    repeat (8) step(1'b1);
    if (rx_count < 150) begin
      fail_with("too few flits made the round trip");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: lpif_link_top.sv
// Logic-link transmit/receive top that joins auto-sync, producer, receive buffer and consumer
`timescale 1ns/1ps

module lpif_link_top
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
#(
  parameter int FIFO_DEPTH = 8,
  parameter int FIFO_START = 2
) (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Control
  input  logic                tx_online,
  input  logic                rx_online,

  // PHY channel
  output logic [PHY_W-1:0]    tx_phy0,
  input  logic [PHY_W-1:0]    rx_phy0,

  // Downstream flit
  input  logic [STATE_W-1:0]  dstrm_state,
  input  logic [PROTID_W-1:0] dstrm_protid,
  input  logic [DATA_W-1:0]   dstrm_data,
  input  logic [0:0]          dstrm_dvalid,
  input  logic [CRC_W-1:0]    dstrm_crc,
  input  logic [0:0]          dstrm_crc_valid,
  input  logic [0:0]          dstrm_valid,

  // Upstream flit
  output logic [STATE_W-1:0]  ustrm_state,
  output logic [PROTID_W-1:0] ustrm_protid,
  output logic [DATA_W-1:0]   ustrm_data,
  output logic [0:0]          ustrm_dvalid,
  output logic [CRC_W-1:0]    ustrm_crc,
  output logic [0:0]          ustrm_crc_valid,
  output logic [0:0]          ustrm_valid,

  // Debug status
  output logic [31:0]         tx_downstream_debug_status,
  output logic [31:0]         rx_upstream_debug_status,

  // Configuration
  input  logic [0:0]          tx_mrk_userbit,
  input  logic [DELAY_W-1:0]  delay_x_value,
  input  logic [DELAY_W-1:0]  delay_y_value,
  input  logic [DELAY_W-1:0]  delay_z_value
);

  logic              tx_online_delay;
  logic              rx_online_delay;
  logic              strobe_tick;
  logic [FLIT_W-1:0] pop_data;
  logic              not_empty;
  logic              pop;
  logic              overflow;

  ////////////////////////////////////////////////////////////////////////////
  // Online sequencing and strobe
  ////////////////////////////////////////////////////////////////////////////

  lpif_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .strobe_tick     (strobe_tick)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////////

  lpif_flit_pack u_flit_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_online_delay (tx_online_delay),
    .strobe_tick     (strobe_tick),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_phy0         (tx_phy0)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////////////////////

  lpif_rx_align_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_START (FIFO_START)
  ) u_rx_align_fifo (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_phy0         (rx_phy0),
    .rx_online_delay (rx_online_delay),
    .pop             (pop),
    .pop_data        (pop_data),
    .not_empty       (not_empty),
    .overflow        (overflow)
  );

  lpif_flit_unpack u_flit_unpack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .pop_data        (pop_data),
    .not_empty       (not_empty),
    .pop             (pop),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Debug status
  ////////////////////////////////////////////////////////////////////////////

  // Both words show the two online levels
  always_comb begin
    tx_downstream_debug_status             = '0;
    tx_downstream_debug_status[TX_DBG_BIT] = tx_online_delay;
    tx_downstream_debug_status[RX_DBG_BIT] = rx_online_delay;

    rx_upstream_debug_status              = '0;
    rx_upstream_debug_status[TX_DBG_BIT]  = tx_online_delay;
    rx_upstream_debug_status[RX_DBG_BIT]  = rx_online_delay;
    // Receive side adds the sticky drop flag
    rx_upstream_debug_status[OVF_DBG_BIT] = overflow;
  end

endmodule

// File: lpif_flit_unpack.sv
// Receive consumer that pops link words and drives the registered upstream flit fields
`timescale 1ns/1ps

module lpif_flit_unpack
  import lpif_flit_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_n,

  // From the receive buffer
  input  logic [FLIT_W-1:0]   pop_data,
  input  logic                not_empty,
  output logic                pop,

  // Upstream flit fields
  output logic [STATE_W-1:0]  ustrm_state,
  output logic [PROTID_W-1:0] ustrm_protid,
  output logic [DATA_W-1:0]   ustrm_data,
  output logic [0:0]          ustrm_dvalid,
  output logic [CRC_W-1:0]    ustrm_crc,
  output logic [0:0]          ustrm_crc_valid,
  output logic [0:0]          ustrm_valid
);

  // No back-pressure upstream
  assign pop = not_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Field split
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= '0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= '0;
      ustrm_valid     <= '0;
    end else begin
      // One-cycle pulse per popped flit
      ustrm_valid[0] <= pop & pop_data[VALID_BIT];
      // Fields hold between flits
      if (pop) begin
        ustrm_state        <= pop_data[STATE_LSB +: STATE_W];
        ustrm_protid       <= pop_data[PROTID_LSB +: PROTID_W];
        ustrm_data         <= pop_data[DATA_LSB +: DATA_W];
        ustrm_dvalid[0]    <= pop_data[DVALID_BIT];
        ustrm_crc          <= pop_data[CRC_LSB +: CRC_W];
        ustrm_crc_valid[0] <= pop_data[CRC_VALID_BIT];
      end
    end
  end

endmodule

// File: lpif_rx_align_fifo.sv
// Receive buffer that aligns on the PHY strobe and releases link words after a fill threshold
`timescale 1ns/1ps

module lpif_rx_align_fifo
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
#(
  parameter int FIFO_DEPTH = 8,
  parameter int FIFO_START = 2
) (
  input  logic              clk_wr,
  input  logic              rst_n,

  input  logic [PHY_W-1:0]  rx_phy0,
  input  logic              rx_online_delay,

  // Consumer side
  input  logic              pop,
  output logic [FLIT_W-1:0] pop_data,
  output logic              not_empty,

  // Sticky
  output logic              overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic              aligned;
  logic              push;
  logic              push_ok;
  logic              full;
  logic              draining;
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  count_next;
  logic [FLIT_W-1:0] mem [FIFO_DEPTH];

  // Wrap at depth, works for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Strobe alignment and push filter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      aligned <= 1'b0;
    end else if (!rx_online_delay) begin
      aligned <= 1'b0;
    end else if (rx_phy0[STB_BIT]) begin
      aligned <= 1'b1;
    end
  end

  // Strobe word itself is not taken, aligned is still low there
  assign push    = aligned & rx_phy0[ONLINE_BIT] & rx_phy0[VALID_BIT];
  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign push_ok = push & ~full;

  ////////////////////////////////////////////////////////////////////////////
  // Circular store
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (push_ok) begin
      mem[wr_ptr] <= rx_phy0[FLIT_W-1:0];
    end
  end

  assign pop_data = mem[rd_ptr];

  always_comb begin
    count_next = count;
    case ({push_ok, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Start threshold and overflow
  ////////////////////////////////////////////////////////////////////////////

  // Held back until FIFO_START entries, then drains until empty
  assign not_empty = (count != '0) & (draining | (count >= CNT_W'(FIFO_START)));

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      draining <= 1'b0;
      overflow <= 1'b0;
    end else begin
      // Empty re-arms the threshold
      draining <= (count_next != '0) & (draining | not_empty);
      if (push & full) begin
        overflow <= 1'b1;
      end
    end
  end

  // Consumer honours the release gate
  a_pop_gated : assert property (
    @(posedge clk_wr) disable iff (!rst_n) pop |-> not_empty);

  a_count_bound : assert property (
    @(posedge clk_wr) disable iff (!rst_n) count <= CNT_W'(FIFO_DEPTH));

endmodule

// File: lpif_flit_pack.sv
// Transmit producer that packs downstream flit fields into the registered PHY word
`timescale 1ns/1ps

module lpif_flit_pack
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_n,

  // Downstream flit fields
  input  logic [STATE_W-1:0]  dstrm_state,
  input  logic [PROTID_W-1:0] dstrm_protid,
  input  logic [DATA_W-1:0]   dstrm_data,
  input  logic [0:0]          dstrm_dvalid,
  input  logic [CRC_W-1:0]    dstrm_crc,
  input  logic [0:0]          dstrm_crc_valid,
  input  logic [0:0]          dstrm_valid,

  // From auto-sync
  input  logic                tx_online_delay,
  input  logic                strobe_tick,

  input  logic [0:0]          tx_mrk_userbit,

  output logic [PHY_W-1:0]    tx_phy0
);

  logic [FLIT_W-1:0] link_word;
  logic [PHY_W-1:0]  phy_next;

  ////////////////////////////////////////////////////////////////////////////
  // Link word packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    link_word = '0;
    link_word[STATE_LSB +: STATE_W]   = dstrm_state;
    link_word[PROTID_LSB +: PROTID_W] = dstrm_protid;
    link_word[DATA_LSB +: DATA_W]     = dstrm_data;
    link_word[DVALID_BIT]             = dstrm_dvalid[0];
    link_word[CRC_LSB +: CRC_W]       = dstrm_crc;
    link_word[CRC_VALID_BIT]          = dstrm_crc_valid[0];
    link_word[VALID_BIT]              = dstrm_valid[0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // PHY word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    phy_next = '0;
    // Strobe runs even before online, for receive alignment
    phy_next[STB_BIT]    = strobe_tick;
    phy_next[MRK_BIT]    = tx_mrk_userbit[0] & tx_online_delay;
    phy_next[ONLINE_BIT] = tx_online_delay;
    // Payload quiet until online
    if (tx_online_delay) begin
      phy_next[FLIT_W-1:0] = link_word;
    end
  end

  // One cycle from dstrm fields to the channel
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= phy_next;
    end
  end

endmodule

// File: lpif_auto_sync.sv
// Online delay sequencing and strobe period generation, instantiated once by the link top
`timescale 1ns/1ps

module lpif_auto_sync
  import aib_phy_pkg::*;
(
  input  logic               clk_wr,
  input  logic               rst_n,

  // Raw online requests
  input  logic               tx_online,
  input  logic               rx_online,

  // Delays in clk_wr cycles
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               strobe_tick
);

  // Channel 0 is transmit, channel 1 is receive
  logic [1:0]         sync_req;
  logic [DELAY_W-1:0] sync_limit [2];
  // One extra bit so the count can reach limit + 1
  logic [DELAY_W:0]   sync_cnt   [2];
  logic [1:0]         sync_lvl;

  logic [DELAY_W-1:0] z_last;
  logic [DELAY_W-1:0] z_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Online delays
  ////////////////////////////////////////////////////////////////////////////

  // Receive only counts once transmit is fully online
  // tx_online term drops rx in the same edge as tx
  assign sync_req[0]   = tx_online;
  assign sync_req[1]   = rx_online & tx_online & sync_lvl[0];

  assign sync_limit[0] = delay_x_value;
  assign sync_limit[1] = delay_y_value;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        sync_cnt[i] <= '0;
        sync_lvl[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!sync_req[i]) begin
          // Request gone, restart from zero
          sync_cnt[i] <= '0;
          sync_lvl[i] <= 1'b0;
        end else begin
          // Saturate at limit + 1
          if (sync_cnt[i] <= {1'b0, sync_limit[i]}) begin
            sync_cnt[i] <= sync_cnt[i] + 1'b1;
          end
          // Level rises limit + 1 edges after the first high sample
          sync_lvl[i] <= (sync_cnt[i] > {1'b0, sync_limit[i]});
        end
      end
    end
  end

  assign tx_online_delay = sync_lvl[0];
  assign rx_online_delay = sync_lvl[1];

  ////////////////////////////////////////////////////////////////////////////
  // Strobe period
  ////////////////////////////////////////////////////////////////////////////

  // Zero period behaves as one
  assign z_last = (delay_z_value == '0) ? '0 : delay_z_value - 1'b1;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      z_cnt       <= '0;
      strobe_tick <= 1'b0;
    end else if (z_cnt >= z_last) begin
      // Also recovers if Z shrinks below the running count
      z_cnt       <= '0;
      strobe_tick <= 1'b1;
    end else begin
      z_cnt       <= z_cnt + 1'b1;
      strobe_tick <= 1'b0;
    end
  end

  // Receive side never comes up ahead of transmit
  a_rx_after_tx : assert property (
    @(posedge clk_wr) disable iff (!rst_n) rx_online_delay |-> tx_online_delay);

endmodule

// File: aib_phy_pkg.sv
// PHY word control bit positions and debug status layout, shared by link and sync logic
package aib_phy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // PHY word
  ////////////////////////////////////////////////////////////////////////////

  // One channel word per clk_wr cycle
  localparam int PHY_W       = 80;

  // Alignment strobe, periodic
  localparam int STB_BIT     = 79;
  // User marker bit
  localparam int MRK_BIT     = 78;
  // Sender has finished its online delay
  localparam int ONLINE_BIT  = 77;
  // Link word sits in the low bits below ONLINE_BIT

  ////////////////////////////////////////////////////////////////////////////
  // Sync configuration
  ////////////////////////////////////////////////////////////////////////////

  // Width of the X, Y and Z delay values
  localparam int DELAY_W     = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Debug status words, 32 bits each
  ////////////////////////////////////////////////////////////////////////////

  localparam int TX_DBG_BIT  = 19;
  localparam int RX_DBG_BIT  = 18;
  // Receive word only
  localparam int OVF_DBG_BIT = 0;

endpackage

// File: lpif_flit_pkg.sv
// Link word layout for the logic-link flit, imported by the producer, buffer and consumer
package lpif_flit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link word size
  ////////////////////////////////////////////////////////////////////////////

  // Whole flit as carried below the PHY control bits
  localparam int FLIT_W        = 77;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths and offsets, MSB first
  ////////////////////////////////////////////////////////////////////////////

  // Link state
  localparam int STATE_W       = 4;
  localparam int STATE_LSB     = 73;

  // Protocol id
  localparam int PROTID_W      = 2;
  localparam int PROTID_LSB    = 71;

  // Payload data
  localparam int DATA_W        = 64;
  localparam int DATA_LSB      = 7;

  // Payload qualifier
  localparam int DVALID_BIT    = 6;

  // CRC nibble and its qualifier
  localparam int CRC_W         = 4;
  localparam int CRC_LSB       = 2;
  localparam int CRC_VALID_BIT = 1;

  // Flit present in this word
  localparam int VALID_BIT     = 0;

endpackage
